// File: bus_pkg.sv
package bus_pkg;

    // Word address, the byte address without bit 0
    typedef logic [19:1] bus_addr_t;

    typedef logic [15:0] bus_data_t;

    // Bit 0 is the low byte lane, bit 1 the high byte lane
    typedef logic [1:0] bus_bytesel_t;

    // Register word offset from address bits 3 to 1
    typedef logic [2:0] reg_offset_t;

    // CRTC index in the low byte, CRTC value in the high byte
    localparam reg_offset_t off_index_value = 3'd2;

    // Mode register in the low byte, colour register in the high byte
    localparam reg_offset_t off_mode_color = 3'd4;

    // Status register in the low byte, read only
    localparam reg_offset_t off_status = 3'd5;

endpackage

// File: vga_pkg.sv
package vga_pkg;

    typedef logic [3:0] crtc_index_t;

    // Character address of the cursor
    typedef logic [14:0] cursor_pos_t;

    // Scan line within a character cell
    typedef logic [2:0] scan_line_t;

    typedef logic [3:0] color_t;

    // CRTC registers reached through the index/value pair
    localparam crtc_index_t crtc_cursor_start = 4'ha;
    localparam crtc_index_t crtc_cursor_end = 4'hb;
    localparam crtc_index_t crtc_cursor_hi = 4'he;
    localparam crtc_index_t crtc_cursor_lo = 4'hf;

    // Horizontal timing in pixel clocks
    localparam int h_total = 24;
    localparam int h_sync_start = 16;
    localparam int h_sync_len = 4;

    // Vertical timing in lines
    localparam int v_total = 10;
    localparam int v_sync_start = 7;
    localparam int v_sync_len = 2;

    // Counter widths follow from the totals
    typedef logic [$clog2(h_total)-1:0] h_count_t;
    typedef logic [$clog2(v_total)-1:0] v_count_t;

endpackage

// File: bit_sync.sv
`timescale 1ns/10ps

module bit_sync (
    input  logic clk,
    input  logic reset,
    input  logic d,
    output logic q
);

    // First stage may go metastable
    logic meta;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            meta <= 1'b0;
            q <= 1'b0;
        end else begin
            meta <= d;
            q <= meta;
        end
    end

endmodule

// File: mcp.sv
`timescale 1ns/10ps

module mcp #(
    parameter int width = 8,
    parameter logic [width-1:0] reset_val = '0
) (
    input  logic             reset,
    // Sending side
    input  logic             clk_a,
    output logic             a_ready,
    input  logic [width-1:0] a_datain,
    input  logic             a_send,
    // Receiving side
    input  logic             clk_b,
    output logic [width-1:0] b_data,
    output logic             b_load
);

    logic             a_req;
    logic             a_ack;
    logic [width-1:0] a_hold;
    logic             b_req;
    logic             b_req_prev;
    logic             b_edge;

    // Ready whenever the acknowledge has caught up with the request
    assign a_ready = (a_req == a_ack);

    always_ff @(posedge clk_a or posedge reset) begin
        if (reset)
            a_req <= 1'b0;
        else if (a_send && a_ready)
            a_req <= ~a_req;
    end

    // Held stable until the other side acknowledges
    always_ff @(posedge clk_a) begin
        if (a_send && a_ready)
            a_hold <= a_datain;
    end

    bit_sync u_req_sync (
        .clk   (clk_b),
        .reset (reset),
        .d     (a_req),
        .q     (b_req)
    );

    assign b_edge = b_req ^ b_req_prev;

    // The delayed request toggle is the acknowledge toggle
    always_ff @(posedge clk_b or posedge reset) begin
        if (reset) begin
            b_req_prev <= 1'b0;
            b_load <= 1'b0;
            b_data <= reset_val;
        end else begin
            b_req_prev <= b_req;
            b_load <= b_edge;
            if (b_edge)
                b_data <= a_hold;
        end
    end

    bit_sync u_ack_sync (
        .clk   (clk_a),
        .reset (reset),
        .d     (b_req_prev),
        .q     (a_ack)
    );

endmodule

// File: vga_sync_gen.sv
`timescale 1ns/10ps

module vga_sync_gen (
    input  logic clk,
    input  logic reset,
    output logic hsync,
    output logic vsync
);

    vga_pkg::h_count_t h_count;
    vga_pkg::v_count_t v_count;
    logic              h_last;
    logic              v_last;
    logic              h_in_sync;
    logic              v_in_sync;

    assign h_last = (h_count == vga_pkg::h_count_t'(vga_pkg::h_total - 1));
    assign v_last = (v_count == vga_pkg::v_count_t'(vga_pkg::v_total - 1));

    // Sync windows in counter terms
    assign h_in_sync =
        (h_count >= vga_pkg::h_count_t'(vga_pkg::h_sync_start)) &&
        (h_count < vga_pkg::h_count_t'(vga_pkg::h_sync_start + vga_pkg::h_sync_len));
    assign v_in_sync =
        (v_count >= vga_pkg::v_count_t'(vga_pkg::v_sync_start)) &&
        (v_count < vga_pkg::v_count_t'(vga_pkg::v_sync_start + vga_pkg::v_sync_len));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            // Line done, step the frame counter
            if (v_last)
                v_count <= '0;
            else
                v_count <= v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Both syncs are active low and idle high out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= ~h_in_sync;
            vsync <= ~v_in_sync;
        end
    end

endmodule

// File: vga_registers.sv
`timescale 1ns/10ps

module vga_registers (
    input  logic                  clk,
    input  logic                  vga_clk,
    input  logic                  reset,
    // CPU bus
    input  logic                  cs,
    input  bus_pkg::bus_addr_t    addr,
    input  bus_pkg::bus_data_t    data_in,
    output bus_pkg::bus_data_t    data_out,
    input  bus_pkg::bus_bytesel_t bytesel,
    input  logic                  wr_en,
    input  logic                  access,
    output logic                  ack,
    // Sync outputs from the pixel domain
    input  logic                  vga_hsync,
    input  logic                  vga_vsync,
    // Configuration on vga_clk
    output logic                  cursor_enabled,
    output logic                  graphics_enabled,
    output vga_pkg::color_t       background_color,
    output logic                  bright_colors,
    output logic                  palette_sel,
    output vga_pkg::cursor_pos_t  cursor_pos,
    output vga_pkg::scan_line_t   cursor_scan_start,
    output vga_pkg::scan_line_t   cursor_scan_end
);

    bus_pkg::reg_offset_t offset;
    logic                 reg_access;
    logic                 sel_index;
    logic                 sel_value;
    logic                 sel_mode;
    logic                 sel_color;
    logic                 sel_status;

    vga_pkg::crtc_index_t active_index;
    vga_pkg::crtc_index_t index;
    logic [7:0]           index_value;
    logic [7:0]           status;

    // System-domain copies of the configuration
    logic [1:0]           cursor_mode;
    logic                 display_enabled;
    logic                 text_enabled;
    logic                 sys_graphics_enabled;
    logic                 sys_bright_colors;
    logic                 sys_palette_sel;
    logic                 sys_cursor_enabled;
    vga_pkg::cursor_pos_t sys_cursor_pos;
    vga_pkg::scan_line_t  sys_cursor_scan_start;
    vga_pkg::scan_line_t  sys_cursor_scan_end;
    vga_pkg::color_t      sys_background_color;

    // Multi-cycle transfer handshake
    logic                 rdy_cursor_pos;
    logic                 rdy_scan_start;
    logic                 rdy_scan_end;
    logic                 rdy_background;
    logic                 vga_send;
    logic                 load_cursor_pos;
    logic                 load_scan_start;
    logic                 load_scan_end;
    logic                 load_background;
    vga_pkg::cursor_pos_t vga_cursor_pos;
    vga_pkg::scan_line_t  vga_scan_start;
    vga_pkg::scan_line_t  vga_scan_end;
    vga_pkg::color_t      vga_background;

    logic                 hsync;
    logic                 vsync;

    assign offset = addr[3:1];
    assign reg_access = cs && access;

    assign sel_index = reg_access && offset == bus_pkg::off_index_value && bytesel[0];
    assign sel_value = reg_access && offset == bus_pkg::off_index_value && bytesel[1];
    assign sel_mode = reg_access && offset == bus_pkg::off_mode_color && bytesel[0];
    assign sel_color = reg_access && offset == bus_pkg::off_mode_color && bytesel[1];
    assign sel_status = reg_access && offset == bus_pkg::off_status && bytesel[0];

    // An index written alongside a value access applies at once
    assign index = (wr_en && sel_index) ? data_in[3:0] : active_index;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_index <= '0;
            cursor_mode <= '0;
            sys_cursor_scan_start <= '0;
            sys_cursor_scan_end <= '0;
            sys_cursor_pos <= '0;
        end else begin
            if (wr_en && sel_index)
                active_index <= data_in[3:0];
            if (wr_en && sel_value) begin
                case (index)
                    vga_pkg::crtc_cursor_start: begin
                        cursor_mode <= data_in[13:12];
                        sys_cursor_scan_start <= data_in[10:8];
                    end
                    vga_pkg::crtc_cursor_end: sys_cursor_scan_end <= data_in[10:8];
                    vga_pkg::crtc_cursor_hi: sys_cursor_pos[14:8] <= data_in[14:8];
                    vga_pkg::crtc_cursor_lo: sys_cursor_pos[7:0] <= data_in[15:8];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            display_enabled <= 1'b0;
            sys_graphics_enabled <= 1'b0;
            text_enabled <= 1'b0;
        end else if (wr_en && sel_mode) begin
            display_enabled <= data_in[3];
            sys_graphics_enabled <= data_in[1];
            text_enabled <= data_in[0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sys_palette_sel <= 1'b0;
            sys_bright_colors <= 1'b0;
            sys_background_color <= '0;
        end else if (wr_en && sel_color) begin
            {sys_palette_sel, sys_bright_colors, sys_background_color} <= data_in[13:8];
        end
    end

    // Cursor mode 1 hides the cursor; registered so the synchronizer sees no glitch
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            sys_cursor_enabled <= 1'b1;
        else
            sys_cursor_enabled <= (cursor_mode != 2'b01);
    end

    always_comb begin
        case (index)
            vga_pkg::crtc_cursor_start:
                index_value = {2'b0, cursor_mode, 1'b0, sys_cursor_scan_start};
            vga_pkg::crtc_cursor_end: index_value = {5'b0, sys_cursor_scan_end};
            vga_pkg::crtc_cursor_hi: index_value = {1'b0, sys_cursor_pos[14:8]};
            vga_pkg::crtc_cursor_lo: index_value = sys_cursor_pos[7:0];
            default: index_value = 8'b0;
        endcase
    end

    // Bit 3 vsync active, bit 0 in retrace
    assign status = {4'b0, ~vsync, 2'b0, ~vsync | ~hsync};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_out <= '0;
            ack <= 1'b0;
        end else begin
            ack <= reg_access;
            data_out <= '0;
            if (!wr_en) begin
                if (sel_index)
                    data_out[7:0] <= {4'b0, active_index};
                if (sel_mode)
                    data_out[7:0] <= {4'b0, display_enabled, 1'b0,
                                      sys_graphics_enabled, text_enabled};
                if (sel_status)
                    data_out[7:0] <= status;
                if (sel_value)
                    data_out[15:8] <= index_value;
                if (sel_color)
                    data_out[15:8] <= {2'b0, sys_palette_sel, sys_bright_colors,
                                       sys_background_color};
            end
        end
    end

    bit_sync u_hsync_sync (.clk(clk), .reset(reset), .d(vga_hsync), .q(hsync));
    bit_sync u_vsync_sync (.clk(clk), .reset(reset), .d(vga_vsync), .q(vsync));
    bit_sync u_graphics_sync (
        .clk(vga_clk), .reset(reset), .d(sys_graphics_enabled), .q(graphics_enabled));
    bit_sync u_bright_sync (
        .clk(vga_clk), .reset(reset), .d(sys_bright_colors), .q(bright_colors));
    bit_sync u_cursor_en_sync (
        .clk(vga_clk), .reset(reset), .d(sys_cursor_enabled), .q(cursor_enabled));
    bit_sync u_palette_sync (
        .clk(vga_clk), .reset(reset), .d(sys_palette_sel), .q(palette_sel));

    // All four fields launch together so they land as one coherent set
    assign vga_send = rdy_cursor_pos && rdy_scan_start && rdy_scan_end && rdy_background;

    mcp #(.width($bits(vga_pkg::cursor_pos_t)), .reset_val('0)) u_cursor_pos_mcp (
        .reset(reset), .clk_a(clk), .a_ready(rdy_cursor_pos), .a_datain(sys_cursor_pos),
        .a_send(vga_send), .clk_b(vga_clk), .b_data(vga_cursor_pos),
        .b_load(load_cursor_pos));
    mcp #(.width($bits(vga_pkg::scan_line_t)), .reset_val('0)) u_scan_start_mcp (
        .reset(reset), .clk_a(clk), .a_ready(rdy_scan_start),
        .a_datain(sys_cursor_scan_start), .a_send(vga_send), .clk_b(vga_clk),
        .b_data(vga_scan_start), .b_load(load_scan_start));
    mcp #(.width($bits(vga_pkg::scan_line_t)), .reset_val('0)) u_scan_end_mcp (
        .reset(reset), .clk_a(clk), .a_ready(rdy_scan_end), .a_datain(sys_cursor_scan_end),
        .a_send(vga_send), .clk_b(vga_clk), .b_data(vga_scan_end),
        .b_load(load_scan_end));
    mcp #(.width($bits(vga_pkg::color_t)), .reset_val('0)) u_background_mcp (
        .reset(reset), .clk_a(clk), .a_ready(rdy_background),
        .a_datain(sys_background_color), .a_send(vga_send), .clk_b(vga_clk),
        .b_data(vga_background), .b_load(load_background));

    always_ff @(posedge vga_clk or posedge reset) begin
        if (reset) begin
            cursor_pos <= '0;
            cursor_scan_start <= '0;
            cursor_scan_end <= '0;
            background_color <= '0;
        end else begin
            if (load_cursor_pos)
                cursor_pos <= vga_cursor_pos;
            if (load_scan_start)
                cursor_scan_start <= vga_scan_start;
            if (load_scan_end)
                cursor_scan_end <= vga_scan_end;
            if (load_background)
                background_color <= vga_background;
        end
    end

endmodule

// File: vga_ctrl_top.sv
`timescale 1ns/10ps

module vga_ctrl_top (
    input  logic                  clk,
    input  logic                  vga_clk,
    input  logic                  reset,
    // CPU bus
    input  logic                  cs,
    input  bus_pkg::bus_addr_t    addr,
    input  bus_pkg::bus_data_t    data_in,
    output bus_pkg::bus_data_t    data_out,
    input  bus_pkg::bus_bytesel_t bytesel,
    input  logic                  wr_en,
    input  logic                  access,
    output logic                  ack,
    // Display sync, active low
    output logic                  hsync,
    output logic                  vsync,
    // Configuration on vga_clk
    output logic                  cursor_enabled,
    output logic                  graphics_enabled,
    output vga_pkg::color_t       background_color,
    output logic                  bright_colors,
    output logic                  palette_sel,
    output vga_pkg::cursor_pos_t  cursor_pos,
    output vga_pkg::scan_line_t   cursor_scan_start,
    output vga_pkg::scan_line_t   cursor_scan_end
);

    vga_registers u_vga_registers (
        .clk               (clk),
        .vga_clk           (vga_clk),
        .reset             (reset),
        .cs                (cs),
        .addr              (addr),
        .data_in           (data_in),
        .data_out          (data_out),
        .bytesel           (bytesel),
        .wr_en             (wr_en),
        .access            (access),
        .ack               (ack),
        .vga_hsync         (hsync),
        .vga_vsync         (vsync),
        .cursor_enabled    (cursor_enabled),
        .graphics_enabled  (graphics_enabled),
        .background_color  (background_color),
        .bright_colors     (bright_colors),
        .palette_sel       (palette_sel),
        .cursor_pos        (cursor_pos),
        .cursor_scan_start (cursor_scan_start),
        .cursor_scan_end   (cursor_scan_end)
    );

    // Runs on the pixel clock
    vga_sync_gen u_vga_sync_gen (
        .clk   (vga_clk),
        .reset (reset),
        .hsync (hsync),
        .vsync (vsync)
    );

endmodule

// File: vga_ctrl_props.sv
`timescale 1ns/10ps

module vga_ctrl_props (
    input logic               clk,
    input logic               reset,
    input logic               cs,
    input logic               access,
    input logic               wr_en,
    input logic               ack,
    input bus_pkg::bus_data_t data_out
);

    // Fixed one-cycle bus latency
    ack_follows_access: assert property (@(posedge clk) disable iff (reset)
        ack == $past(cs && access))
        else $error("ack does not follow access and cs by one cycle");

    data_zero_idle: assert property (@(posedge clk) disable iff (reset)
        !ack |-> data_out == '0)
        else $error("data_out is not zero while ack is low");

    // A write acknowledge carries no read data
    data_zero_write: assert property (@(posedge clk) disable iff (reset)
        (cs && access && wr_en) |=> data_out == '0)
        else $error("data_out is not zero in the cycle after a write");

endmodule

bind vga_registers vga_ctrl_props u_vga_ctrl_props (
    .clk      (clk),
    .reset    (reset),
    .cs       (cs),
    .access   (access),
    .wr_en    (wr_en),
    .ack      (ack),
    .data_out (data_out)
);

// File: vga_ctrl_tb.sv
`timescale 1ns/10ps

module vga_ctrl_tb;

    localparam int ack_limit = 16;
    localparam int cross_limit = 200;
    // One frame in clk cycles, clk runs 1.5 times faster than vga_clk
    localparam int frame_clks = vga_pkg::h_total * vga_pkg::v_total * 3 / 2;
    localparam int status_limit = 2 * frame_clks;

    logic                  clk = 1'b0;
    logic                  vga_clk = 1'b0;
    logic                  reset;
    logic                  cs;
    bus_pkg::bus_addr_t    addr;
    bus_pkg::bus_data_t    data_in;
    bus_pkg::bus_data_t    data_out;
    bus_pkg::bus_bytesel_t bytesel;
    logic                  wr_en;
    logic                  access;
    logic                  ack;
    logic                  hsync;
    logic                  vsync;
    logic                  cursor_enabled;
    logic                  graphics_enabled;
    vga_pkg::color_t       background_color;
    logic                  bright_colors;
    logic                  palette_sel;
    vga_pkg::cursor_pos_t  cursor_pos;
    vga_pkg::scan_line_t   cursor_scan_start;
    vga_pkg::scan_line_t   cursor_scan_end;

    integer seed = 20;
    integer errors = 0;
    integer tests = 0;
    integer failed_tests = 0;
    integer start_errors;
    integer vs_low_cnt = 0;
    integer hs_low_cnt = 0;
    logic   timed_out = 1'b0;

    // Shadow copy of the register state
    vga_pkg::crtc_index_t m_index;
    logic [1:0]           m_cursor_mode;
    vga_pkg::scan_line_t  m_start;
    vga_pkg::scan_line_t  m_end;
    vga_pkg::cursor_pos_t m_pos;
    logic                 m_display;
    logic                 m_graphics;
    logic                 m_text;
    logic                 m_palette;
    logic                 m_bright;
    vga_pkg::color_t      m_background;

    always #2 clk = ~clk;
    always #3 vga_clk = ~vga_clk;

    // Length of the current sync low stretches in clk cycles
    always @(posedge clk) begin
        if (vsync)
            vs_low_cnt = 0;
        else
            vs_low_cnt = vs_low_cnt + 1;
        if (hsync)
            hs_low_cnt = 0;
        else
            hs_low_cnt = hs_low_cnt + 1;
    end

    vga_ctrl_top u_vga_ctrl_top (
        .clk(clk), .vga_clk(vga_clk), .reset(reset), .cs(cs), .addr(addr),
        .data_in(data_in), .data_out(data_out), .bytesel(bytesel), .wr_en(wr_en),
        .access(access), .ack(ack), .hsync(hsync), .vsync(vsync),
        .cursor_enabled(cursor_enabled), .graphics_enabled(graphics_enabled),
        .background_color(background_color), .bright_colors(bright_colors),
        .palette_sel(palette_sel), .cursor_pos(cursor_pos),
        .cursor_scan_start(cursor_scan_start), .cursor_scan_end(cursor_scan_end)
    );

    // Called on a falling edge, returns one idle cycle after ack
    task automatic bus_access(input bus_pkg::reg_offset_t off, input bus_pkg::bus_bytesel_t lanes,
                              input logic write, input bus_pkg::bus_data_t wdata,
                              output bus_pkg::bus_data_t rdata);
        integer count;
        count = 0;
        rdata = '0;
        if (!timed_out) begin
            addr = bus_pkg::bus_addr_t'(off);
            bytesel = lanes;
            wr_en = write;
            data_in = wdata;
            cs = 1'b1;
            access = 1'b1;
            @(negedge clk);
            while (!ack && count < ack_limit) begin
                @(negedge clk);
                count = count + 1;
            end
            if (!ack) begin
                $display("Bus timeout: no ack within %0d cycles at %0t ns", ack_limit, $time);
                timed_out = 1'b1;
            end
            rdata = data_out;
            cs = 1'b0;
            access = 1'b0;
            wr_en = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic bus_write(input bus_pkg::reg_offset_t off, input bus_pkg::bus_bytesel_t lanes,
                             input bus_pkg::bus_data_t wdata);
        bus_pkg::bus_data_t unused;
        bus_access(off, lanes, 1'b1, wdata, unused);
    endtask

    task automatic bus_read(input bus_pkg::reg_offset_t off, input bus_pkg::bus_bytesel_t lanes,
                            output bus_pkg::bus_data_t rdata);
        bus_access(off, lanes, 1'b0, '0, rdata);
    endtask

    function automatic logic [7:0] model_value(input vga_pkg::crtc_index_t idx);
        case (idx)
            vga_pkg::crtc_cursor_start: return {2'b0, m_cursor_mode, 1'b0, m_start};
            vga_pkg::crtc_cursor_end: return {5'b0, m_end};
            vga_pkg::crtc_cursor_hi: return {1'b0, m_pos[14:8]};
            vga_pkg::crtc_cursor_lo: return m_pos[7:0];
            default: return 8'h00;
        endcase
    endfunction

    function automatic bus_pkg::bus_data_t expected_index_value();
        return {model_value(m_index), 4'h0, m_index};
    endfunction

    function automatic bus_pkg::bus_data_t expected_mode_color();
        return {2'b0, m_palette, m_bright, m_background,
                4'b0, m_display, 1'b0, m_graphics, m_text};
    endfunction

    // Index and value written in one access
    task automatic crtc_write(input vga_pkg::crtc_index_t idx, input logic [7:0] val);
        bus_write(bus_pkg::off_index_value, 2'b11, {val, 4'h0, idx});
        m_index = idx;
        case (idx)
            vga_pkg::crtc_cursor_start: begin
                m_cursor_mode = val[5:4];
                m_start = val[2:0];
            end
            vga_pkg::crtc_cursor_end: m_end = val[2:0];
            vga_pkg::crtc_cursor_hi: m_pos[14:8] = val[6:0];
            vga_pkg::crtc_cursor_lo: m_pos[7:0] = val;
            default: ;
        endcase
    endtask

    task automatic mode_color_write(input bus_pkg::bus_data_t wdata,
                                    input bus_pkg::bus_bytesel_t lanes);
        bus_write(bus_pkg::off_mode_color, lanes, wdata);
        if (lanes[0]) begin
            m_display = wdata[3];
            m_graphics = wdata[1];
            m_text = wdata[0];
        end
        if (lanes[1]) begin
            m_palette = wdata[13];
            m_bright = wdata[12];
            m_background = wdata[11:8];
        end
    endtask

    task automatic check_data(input string what, input bus_pkg::bus_data_t got,
                              input bus_pkg::bus_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_pos(input string what, input vga_pkg::cursor_pos_t got,
                             input vga_pkg::cursor_pos_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_line(input string what, input vga_pkg::scan_line_t got,
                              input vga_pkg::scan_line_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_color(input string what, input vga_pkg::color_t got,
                               input vga_pkg::color_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    // Waits for every pixel-domain output to reach the model, then compares
    task automatic wait_outputs();
        integer count;
        logic   exp_cursor_en;
        count = 0;
        exp_cursor_en = (m_cursor_mode != 2'b01);
        while (count < cross_limit && (cursor_pos !== m_pos || cursor_scan_start !== m_start ||
               cursor_scan_end !== m_end || background_color !== m_background ||
               cursor_enabled !== exp_cursor_en || graphics_enabled !== m_graphics ||
               bright_colors !== m_bright || palette_sel !== m_palette)) begin
            @(negedge clk);
            count = count + 1;
        end
        check_pos("cursor_pos", cursor_pos, m_pos);
        check_line("cursor_scan_start", cursor_scan_start, m_start);
        check_line("cursor_scan_end", cursor_scan_end, m_end);
        check_color("background_color", background_color, m_background);
        check_bit("cursor_enabled", cursor_enabled, exp_cursor_en);
        check_bit("graphics_enabled", graphics_enabled, m_graphics);
        check_bit("bright_colors", bright_colors, m_bright);
        check_bit("palette_sel", palette_sel, m_palette);
    endtask

    task automatic begin_test();
        start_errors = errors;
        tests = tests + 1;
    endtask

    task automatic end_test(input string name);
        if (errors != start_errors || timed_out) begin
            failed_tests = failed_tests + 1;
            $display("Test %0d %s: failed", tests, name);
        end else begin
            $display("Test %0d %s: passed", tests, name);
        end
    endtask

    initial begin
        bus_pkg::bus_data_t   rdata;
        logic [31:0]          rnd;
        vga_pkg::crtc_index_t idx;
        integer               count;
        logic                 seen_set;
        logic                 seen_clear;
        logic                 seen_vs;
        logic                 checked_vs;
        logic                 checked_hs;

        reset = 1'b1;
        cs = 1'b0;
        access = 1'b0;
        wr_en = 1'b0;
        addr = '0;
        data_in = '0;
        bytesel = '0;
        {m_index, m_cursor_mode, m_start, m_end, m_pos} = '0;
        {m_display, m_graphics, m_text, m_palette, m_bright, m_background} = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        begin_test();
        bus_read(bus_pkg::off_mode_color, 2'b11, rdata);
        check_data("mode/colour after reset", rdata, 16'h0000);
        wait_outputs();
        end_test("reset state");

        begin_test();
        for (int i = 0; i < 32; i++) begin
            rnd = $random(seed);
            idx = rnd[19:16];
            if (rnd[20]) begin
                case (rnd[22:21])
                    2'd0: idx = vga_pkg::crtc_cursor_start;
                    2'd1: idx = vga_pkg::crtc_cursor_end;
                    2'd2: idx = vga_pkg::crtc_cursor_hi;
                    default: idx = vga_pkg::crtc_cursor_lo;
                endcase
            end
            crtc_write(idx, rnd[7:0]);
            bus_read(bus_pkg::off_index_value, 2'b11, rdata);
            check_data("CRTC index/value", rdata, expected_index_value());
        end
        end_test("CRTC index/value");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            mode_color_write(rnd[15:0], 2'b11);
            bus_read(bus_pkg::off_mode_color, 2'b11, rdata);
            check_data("mode/colour", rdata, expected_mode_color());
            wait_outputs();
        end
        end_test("mode and colour");

        begin_test();
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            crtc_write(vga_pkg::crtc_cursor_start, rnd[7:0]);
            crtc_write(vga_pkg::crtc_cursor_end, rnd[15:8]);
            rnd = $random(seed);
            crtc_write(vga_pkg::crtc_cursor_hi, rnd[7:0]);
            crtc_write(vga_pkg::crtc_cursor_lo, rnd[15:8]);
            mode_color_write(rnd[31:16], 2'b10);
            wait_outputs();
        end
        end_test("multi-bit crossing");

        begin_test();
        {seen_set, seen_clear, seen_vs, checked_vs, checked_hs} = '0;
        count = 0;
        while (!(seen_set && seen_clear && seen_vs && checked_vs && checked_hs) &&
               count < status_limit && !timed_out) begin
            bus_read(bus_pkg::off_status, 2'b01, rdata);
            if (rdata[0])
                seen_set = 1'b1;
            else
                seen_clear = 1'b1;
            if (rdata[3])
                seen_vs = 1'b1;
            // vsync held low well before the access and still low after it
            if (vs_low_cnt >= 8) begin
                checked_vs = 1'b1;
                check_bit("status vsync flag", rdata[3], 1'b1);
                check_bit("status retrace flag", rdata[0], 1'b1);
            end
            // Same for hsync, whose low stretch is much shorter
            if (hs_low_cnt >= 5) begin
                checked_hs = 1'b1;
                check_bit("status retrace flag on hsync", rdata[0], 1'b1);
            end
            count = count + 1;
        end
        if (!(seen_set && seen_clear && seen_vs && checked_vs && checked_hs)) begin
            $display("Status flags did not all change within %0d reads", status_limit);
            errors = errors + 1;
        end
        end_test("status");

        begin_test();
        // Writes with the high byte lane clear must leave the value and colour alone
        bus_write(bus_pkg::off_index_value, 2'b01,
                  {~m_pos[7:0], 4'h0, vga_pkg::crtc_cursor_lo});
        m_index = vga_pkg::crtc_cursor_lo;
        bus_write(bus_pkg::off_mode_color, 2'b00, ~expected_mode_color());
        rnd = $random(seed);
        mode_color_write({2'b0, ~m_palette, ~m_bright, ~m_background, rnd[7:0]}, 2'b01);
        bus_read(bus_pkg::off_index_value, 2'b11, rdata);
        check_data("CRTC index/value after lane test", rdata, expected_index_value());
        bus_read(bus_pkg::off_mode_color, 2'b11, rdata);
        check_data("mode/colour after lane test", rdata, expected_mode_color());
        end_test("byte lanes");

        $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: project.f
bus_pkg.sv
vga_pkg.sv
bit_sync.sv
mcp.sv
vga_sync_gen.sv
vga_registers.sv
vga_ctrl_top.sv
vga_ctrl_props.sv
vga_ctrl_tb.sv

// File: Bender.yml
package:
  name: vga_ctrl

sources:
  - files:
      - bus_pkg.sv
      - vga_pkg.sv
      - bit_sync.sv
      - mcp.sv
      - vga_sync_gen.sv
      - vga_registers.sv
      - vga_ctrl_top.sv
  - target: test
    files:
      - vga_ctrl_props.sv
      - vga_ctrl_tb.sv
